// File: run.sh
#!/bin/sh
# build and run the console testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f serialConsole.f --top-module consoleTb -o consoleSim

result=$(./obj_dir/consoleSim) || true
echo "$result"
echo "$result" | grep -q "Result: PASSED"

// File: serialConsole.f
+incdir+source
+incdir+test
source/consolePkg.sv
source/messageRom.sv
source/infoRom.sv
source/consoleTransmitter.sv
source/resetMonitor.sv
source/consoleControl.sv
source/consoleTop.sv
test/consoleTb.sv

// File: source/consoleControl.sv
// console command control
`include "console_consts.svh"

module consoleControl (
  input                               clock,
  input                               resetQ,
  input                               rxValid,
  input  consolePkg::charT            rxData,
  input  consolePkg::charT            romChar,
  input  consolePkg::charT            infoByte,
  input                               sendBusy,
  input                               sendDone,
  output consolePkg::romAddrT         romAddr,
  output consolePkg::infoIndexT       infoIndex,
  output logic                        sendStart,
  output consolePkg::charT            sendByte,
  output consolePkg::sendKindT        sendKind
);

  consolePkg::consoleStateT state;
  consolePkg::consoleStateT nextState; // where to go after a message or a confirmed command

  logic             inComment;
  logic             binaryMode;
  logic             inFlight;
  logic             isEnter;
  logic             isCtrlC;
  logic             isBlank;
  consolePkg::charT lowerChar;

  assign inFlight  = sendStart || sendBusy; // busy rises one cycle after the start pulse
  assign isEnter   = (rxData == `CHAR_CR) || (rxData == `CHAR_LF);
  assign isCtrlC   = (rxData == `CHAR_CTRLC);
  assign isBlank   = (rxData == `CHAR_SPACE) || (rxData == `CHAR_TAB);
  assign lowerChar = rxData | 8'h20;

  always_ff @(posedge clock) begin
    if (resetQ) begin
      state <= consolePkg::Banner;
      nextState <= consolePkg::Prompt;
      romAddr <= `ROM_BANNER;
      infoIndex <= '0;
      inComment <= 1'b0;
      binaryMode <= 1'b0;
      sendStart <= 1'b0;
    end
    else begin
      sendStart <= 1'b0;
      case (state)

        consolePkg::Banner : begin
          romAddr <= `ROM_BANNER;
          state <= consolePkg::TxRom;
          nextState <= consolePkg::Prompt;
        end

        consolePkg::Prompt : begin
          romAddr <= `ROM_PROMPT;
          state <= consolePkg::TxRom;
          nextState <= consolePkg::Input;
        end

        consolePkg::Input : begin
          inComment <= 1'b0;
          infoIndex <= '0;
          if (rxValid) begin
            if (lowerChar == "i") begin
              binaryMode <= !rxData[5]; // capital means raw binary dump
              state <= consolePkg::WaitForEnter;
              nextState <= consolePkg::Info;
            end
            else if (isEnter) begin
              state <= consolePkg::Prompt;
            end
            else if (isCtrlC) begin
              romAddr <= `ROM_CTRLC;
              state <= consolePkg::TxRom;
              nextState <= consolePkg::Prompt;
            end
            else if ((rxData != `RESET_CHAR) && (rxData != `SYNC_CHAR)) begin
              state <= consolePkg::SyntaxError;
            end
          end
        end

        // command is complete, only blanks and comments until enter
        consolePkg::WaitForEnter : begin
          if (rxValid) begin
            if (isEnter) begin
              state <= nextState;
            end
            else if (isCtrlC) begin
              romAddr <= `ROM_CTRLC;
              state <= consolePkg::TxRom;
              nextState <= consolePkg::Prompt;
            end
            else if (rxData == `CHAR_COMMENT) begin
              inComment <= 1'b1;
            end
            else if (!isBlank && !inComment) begin
              state <= consolePkg::SyntaxError;
            end
          end
        end

        // let local echo run, report the error on enter
        consolePkg::SyntaxError : begin
          if (rxValid && isEnter) begin
            romAddr <= `ROM_ERROR;
            state <= consolePkg::TxRom;
            nextState <= consolePkg::Prompt;
          end
          else if (rxValid && isCtrlC) begin
            romAddr <= `ROM_CTRLC;
            state <= consolePkg::TxRom;
            nextState <= consolePkg::Prompt;
          end
        end

        consolePkg::TxRom : begin
          if (sendDone) begin
            romAddr <= romAddr + 6'd1;
          end
          else if (!inFlight) begin
            if (romChar == 8'h00) begin
              state <= nextState; // terminator is not sent
            end
            else begin
              sendStart <= 1'b1;
              sendByte <= romChar;
              sendKind <= consolePkg::KindRaw;
            end
          end
        end

        consolePkg::Info : begin
          sendStart <= 1'b1;
          sendByte <= infoByte;
          if (binaryMode) sendKind <= consolePkg::KindBinary;
          else if (infoIndex[1:0] == 2'd0) sendKind <= consolePkg::KindHexCrlf;
          else sendKind <= consolePkg::KindHex;
          state <= consolePkg::InfoWait;
        end

        consolePkg::InfoWait : begin
          if (sendDone) begin
            if (infoIndex == consolePkg::infoIndexT'(`INFO_LENGTH - 1)) begin
              state <= consolePkg::Prompt;
            end
            else begin
              infoIndex <= infoIndex + 5'd1;
              state <= consolePkg::Info;
            end
          end
        end

        default : state <= consolePkg::Banner;
      endcase
    end
  end

  // ********************
  // checks
  // ********************

  noStartWhileBusy : assert property (@(posedge clock) disable iff (resetQ)
    sendStart |-> !sendBusy);

endmodule

// File: source/consolePkg.sv
// serial console types
package consolePkg;

  typedef logic [7:0] charT;      // one console character or data byte
  typedef logic [5:0] romAddrT;   // message rom address
  typedef logic [4:0] infoIndexT; // identity table byte index

  // how the transmitter renders one requested byte
  typedef enum logic [1:0] {
    KindRaw,
    KindHex,
    KindHexCrlf,
    KindBinary
  } sendKindT;

  typedef enum logic [3:0] {
    Banner,
    Prompt,
    Input,
    WaitForEnter,
    SyntaxError,
    TxRom,
    Info,
    InfoWait
  } consoleStateT;

endpackage

// File: source/consoleTop.sv
// serial console top
module consoleTop (
  input                    clock,
  input                    resetQ,
  input                    rxValid,
  input  consolePkg::charT rxData,
  output logic             txValid,
  output consolePkg::charT txData,
  input                    txReady,
  output logic             resetOut
);

  consolePkg::romAddrT   romAddr;
  consolePkg::charT      romChar;
  consolePkg::infoIndexT infoIndex;
  consolePkg::charT      infoByte;
  logic                  sendStart;
  consolePkg::charT      sendByte;
  consolePkg::sendKindT  sendKind;
  logic                  sendBusy;
  logic                  sendDone;

  consoleControl uControl (
    .clock(clock), .resetQ(resetQ),
    .rxValid(rxValid), .rxData(rxData),
    .romChar(romChar), .infoByte(infoByte),
    .sendBusy(sendBusy), .sendDone(sendDone),
    .romAddr(romAddr), .infoIndex(infoIndex),
    .sendStart(sendStart), .sendByte(sendByte), .sendKind(sendKind)
  );

  messageRom uMessageRom (.romAddr(romAddr), .romChar(romChar));

  infoRom uInfoRom (.infoIndex(infoIndex), .infoByte(infoByte));

  consoleTransmitter uTransmitter (
    .clock(clock), .resetQ(resetQ),
    .sendStart(sendStart), .sendByte(sendByte), .sendKind(sendKind),
    .txReady(txReady), .txValid(txValid), .txData(txData),
    .sendBusy(sendBusy), .sendDone(sendDone)
  );

  resetMonitor uResetMonitor (
    .clock(clock), .resetQ(resetQ),
    .rxValid(rxValid), .rxData(rxData),
    .resetOut(resetOut)
  );

endmodule

// File: source/consoleTransmitter.sv
// console character transmitter
`include "console_consts.svh"

module consoleTransmitter (
  input                        clock,
  input                        resetQ,
  input                        sendStart,
  input  consolePkg::charT     sendByte,
  input  consolePkg::sendKindT sendKind,
  input                        txReady,
  output logic                 txValid,
  output consolePkg::charT     txData,
  output logic                 sendBusy,
  output logic                 sendDone
);

  // step 0 CR, 1 LF, 2 high digit, 3 low digit or raw byte
  logic [1:0]       step;
  logic             lastStep;
  logic             accept;
  logic             hexMode;
  consolePkg::charT byteQ;

  function automatic consolePkg::charT hexDigit(input logic [3:0] nibble);
    hexDigit = (nibble < 4'd10) ? (8'h30 + 8'(nibble)) : (8'h37 + 8'(nibble));
  endfunction

  assign txValid  = sendBusy;
  assign accept   = sendBusy && txReady;
  assign lastStep = (step == 2'd3);
  assign sendDone = accept && lastStep;

  always_ff @(posedge clock) begin
    if (resetQ) begin
      sendBusy <= 1'b0;
      step <= 2'd0;
    end
    else if (sendStart) begin
      sendBusy <= 1'b1;
      case (sendKind)
        consolePkg::KindHexCrlf : step <= 2'd0;
        consolePkg::KindHex     : step <= 2'd2;
        default                 : step <= 2'd3; // raw and binary are a single byte
      endcase
    end
    else if (accept) begin
      step <= step + 2'd1;
      if (lastStep) sendBusy <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (sendStart) begin
      byteQ <= sendByte;
      hexMode <= (sendKind == consolePkg::KindHex) || (sendKind == consolePkg::KindHexCrlf);
    end
  end

  // data follows the step register only, so it holds while stalled
  always_comb begin
    case (step)
      2'd0    : txData = `CHAR_CR;
      2'd1    : txData = `CHAR_LF;
      2'd2    : txData = hexDigit(byteQ[7:4]);
      default : txData = hexMode ? hexDigit(byteQ[3:0]) : byteQ;
    endcase
  end

  // ********************
  // checks
  // ********************

  holdUnderStall : assert property (@(posedge clock) disable iff (resetQ)
    (txValid && !txReady) |=> (txValid && $stable(txData)));

endmodule

// File: source/console_consts.svh
// console constants
`ifndef CONSOLE_CONSTS_SVH
`define CONSOLE_CONSTS_SVH

// characters seen by the command parser
`define CHAR_CR      8'h0d
`define CHAR_LF      8'h0a
`define CHAR_TAB     8'h09
`define CHAR_SPACE   8'h20
`define CHAR_CTRLC   8'h03
`define CHAR_COMMENT 8'h23

`define RESET_CHAR   8'h7e
`define SYNC_CHAR    8'h7f
`define RESET_LENGTH 64

// message start addresses in the text rom
`define ROM_BANNER   6'd0
`define ROM_PROMPT   6'd14
`define ROM_CTRLC    6'd20
`define ROM_ERROR    6'd23

// identity table
`define INFO_LENGTH    20
`define INFO_VERSION   8'h01
`define BUILDER_ID     16'hffff
`define BITSTREAM_ID   32'h12345678
`define BUILD_DATE     32'h20210925
`define BUILD_TIME     16'h1200
`define TARGET_VENDOR  16'hffff
`define TARGET_LIBRARY 16'hffff
`define TARGET_BOARD   16'hffff

`endif

// File: source/infoRom.sv
// build identity table
`include "console_consts.svh"

module infoRom (
  input  consolePkg::infoIndexT infoIndex,
  output consolePkg::charT      infoByte
);

  // byte 0 is the first one dumped, so it sits in the top bits
  localparam logic [8*`INFO_LENGTH-1:0] InfoTable = {
    `INFO_VERSION,
    8'h00,          // byte channel count
    `BUILDER_ID,
    `BITSTREAM_ID,
    `BUILD_DATE,
    `BUILD_TIME,
    `TARGET_VENDOR,
    `TARGET_LIBRARY,
    `TARGET_BOARD
  };

  always_comb begin
    if (infoIndex < `INFO_LENGTH) begin
      infoByte = InfoTable[8*(`INFO_LENGTH-1-infoIndex) +: 8];
    end
    else begin
      infoByte = 8'h00;
    end
  end

endmodule

// File: source/messageRom.sv
// console message text
`include "console_consts.svh"

module messageRom (
  input  consolePkg::romAddrT romAddr,
  output consolePkg::charT    romChar
);

  // every message ends in a zero byte which is never sent
  always_comb begin
    case (romAddr)
      `ROM_BANNER + 0  : romChar = `CHAR_CR;
      `ROM_BANNER + 1  : romChar = `CHAR_LF;
      `ROM_BANNER + 2  : romChar = "*";
      `ROM_BANNER + 3  : romChar = " ";
      `ROM_BANNER + 4  : romChar = "O";
      `ROM_BANNER + 5  : romChar = "P";
      `ROM_BANNER + 6  : romChar = "E";
      `ROM_BANNER + 7  : romChar = "N";
      `ROM_BANNER + 8  : romChar = "C";
      `ROM_BANNER + 9  : romChar = "O";
      `ROM_BANNER + 10 : romChar = "S";
      `ROM_BANNER + 11 : romChar = " ";
      `ROM_BANNER + 12 : romChar = "*";
      `ROM_BANNER + 13 : romChar = 8'h00;

      `ROM_PROMPT + 0  : romChar = `CHAR_CR;
      `ROM_PROMPT + 1  : romChar = `CHAR_LF;
      `ROM_PROMPT + 2  : romChar = "O";
      `ROM_PROMPT + 3  : romChar = "C";
      `ROM_PROMPT + 4  : romChar = ">";
      `ROM_PROMPT + 5  : romChar = 8'h00;

      `ROM_CTRLC + 0   : romChar = "^";
      `ROM_CTRLC + 1   : romChar = "C";
      `ROM_CTRLC + 2   : romChar = 8'h00;

      `ROM_ERROR + 0   : romChar = `CHAR_CR;
      `ROM_ERROR + 1   : romChar = `CHAR_LF;
      `ROM_ERROR + 2   : romChar = "E";
      `ROM_ERROR + 3   : romChar = "R";
      `ROM_ERROR + 4   : romChar = "R";
      `ROM_ERROR + 5   : romChar = "O";
      `ROM_ERROR + 6   : romChar = "R";
      `ROM_ERROR + 7   : romChar = 8'h00;

      default          : romChar = 8'h00; // unused space reads as terminator
    endcase
  end

endmodule

// File: source/resetMonitor.sv
// manager reset monitor
`include "console_consts.svh"

module resetMonitor (
  input                    clock,
  input                    resetQ,
  input                    rxValid,
  input  consolePkg::charT rxData,
  output logic             resetOut
);

  localparam int CountWidth = $clog2(`RESET_LENGTH + 1);

  logic [CountWidth-1:0] runCount; // consecutive reset characters, saturating

  always_ff @(posedge clock) begin
    if (resetQ) begin
      runCount <= '0;
      resetOut <= 1'b0;
    end
    else begin
      if (rxValid) begin
        if (rxData != `RESET_CHAR) runCount <= '0;
        else if (runCount < `RESET_LENGTH) runCount <= runCount + 1'b1;
      end
      if (runCount >= `RESET_LENGTH) resetOut <= 1'b1; // sticky until resetQ
    end
  end

  stickyRequest : assert property (@(posedge clock) $fell(resetOut) |-> $past(resetQ));

endmodule

// File: test/consoleModel.svh
// expected console output
`ifndef CONSOLE_MODEL_SVH
`define CONSOLE_MODEL_SVH

`include "console_consts.svh"

logic [7:0] identity [$]; // identity table as the console should dump it

function automatic logic [7:0] hexChar(input logic [3:0] nibble);
  string digits;
  digits = "0123456789ABCDEF";
  return digits.getc(int'(nibble));
endfunction

task automatic expectText(input string text);
  int i;
  for (i = 0; i < text.len(); i++) begin
    expected.push_back(text.getc(i));
  end
endtask

// new line, then the text
task automatic expectLine(input string text);
  expected.push_back(`CHAR_CR);
  expected.push_back(`CHAR_LF);
  expectText(text);
endtask

task automatic addField(input logic [31:0] value, input int bytes);
  int b;
  for (b = bytes - 1; b >= 0; b--) begin
    identity.push_back(value[8*b +: 8]); // most significant byte first
  end
endtask

task automatic expectInfo(input logic rawBytes);
  int i;
  identity.delete();
  addField(`INFO_VERSION, 1);
  addField(8'h00, 1);         // byte channel count
  addField(`BUILDER_ID, 2);
  addField(`BITSTREAM_ID, 4);
  addField(`BUILD_DATE, 4);
  addField(`BUILD_TIME, 2);
  addField(`TARGET_VENDOR, 2);
  addField(`TARGET_LIBRARY, 2);
  addField(`TARGET_BOARD, 2);
  for (i = 0; i < identity.size(); i++) begin
    if (rawBytes) begin
      expected.push_back(identity[i]);
    end
    else begin
      if (i % 4 == 0) expectLine(""); // four bytes per line
      expected.push_back(hexChar(identity[i][7:4]));
      expected.push_back(hexChar(identity[i][3:0]));
    end
  end
endtask

`endif

// File: test/consoleTb.sv
// serial console testbench
module consoleTb;
  timeunit 1ns;
  timeprecision 100ps;

  logic             clock = 1'b0;
  logic             resetQ;
  logic             rxValid;
  consolePkg::charT rxData;
  logic             txValid;
  consolePkg::charT txData;
  logic             txReady;
  logic             resetOut;

  logic [7:0]  expected [$];
  logic [7:0]  received [$];
  logic [15:0] lfsrState = 16'd2645;

  `include "consoleModel.svh"

  consoleTop DUT (
    .clock(clock), .resetQ(resetQ),
    .rxValid(rxValid), .rxData(rxData),
    .txValid(txValid), .txData(txData), .txReady(txReady),
    .resetOut(resetOut)
  );

  always #20 clock = ~clock;

  // ********************
  // helpers
  // ********************

  // galois lfsr, taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic randomBit();
    logic outBit;
    outBit = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (outBit) lfsrState = lfsrState ^ 16'hb400;
    return outBit;
  endfunction

  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] wanted);
    if (actual !== wanted) begin
      failRun($sformatf("Error: %s is 0x%0h, expected 0x%0h", name, actual, wanted));
    end
  endtask

  // one receive strobe, four cycles after the previous one
  task automatic sendChar(input logic [7:0] ch);
    repeat (3) @(posedge clock);
    #2;
    rxValid = 1'b1;
    rxData = ch;
    @(posedge clock);
    #2;
    rxValid = 1'b0;
  endtask

  task automatic sendText(input string text);
    int i;
    for (i = 0; i < text.len(); i++) begin
      sendChar(text.getc(i));
    end
  endtask

  task automatic checkOutput();
    int cycles;
    int i;
    cycles = 0;
    while (received.size() < expected.size()) begin
      @(posedge clock);
      #1;
      cycles++;
      if (cycles > 2000) failRun("console output did not arrive in time");
    end
    for (i = 0; i < expected.size(); i++) begin
      checkValue("txData", received[i], expected[i]);
    end
    expected.delete();
    received.delete();
  endtask

  // resetOut is expected on the second edge after the strobe goes out
  task automatic waitResetOut();
    int edges;
    edges = 1;
    while (!resetOut) begin
      @(posedge clock);
      #1;
      edges++;
      if (edges > 8) failRun("reset request was never raised");
    end
    checkValue("resetOut delay", edges, 2);
  endtask

  // ********************
  // stimulus
  // ********************

  initial begin
    txReady = 1'b0;
    forever begin
      @(posedge clock);
      #2 txReady = randomBit(); // back-pressure on every cycle
    end
  end

  always @(posedge clock) begin
    if (!resetQ && txValid && txReady) received.push_back(txData);
  end

  initial begin
    resetQ = 1'b1;
    rxValid = 1'b0;
    rxData = 8'h00;
    repeat (16) @(posedge clock);
    #2 resetQ = 1'b0;

    expectLine("* OPENCOS *");
    expectLine("OC>");
    checkOutput();

    sendText("i  # note"); // blanks and a comment before enter
    sendChar(`CHAR_CR);
    expectInfo(1'b0);
    expectLine("OC>");
    checkOutput();

    sendText("I");
    sendChar(`CHAR_CR);
    expectInfo(1'b1);
    expectLine("OC>");
    checkOutput();

    sendText("x");
    sendChar(`CHAR_CR);
    expectLine("ERROR");
    expectLine("OC>");
    checkOutput();

    sendText("i");
    sendChar(`CHAR_CTRLC);
    expectText("^C");
    expectLine("OC>");
    checkOutput();

    // broken run of reset characters
    repeat (63) sendChar(`RESET_CHAR);
    sendChar("a");
    repeat (4) @(posedge clock);
    checkValue("resetOut", resetOut, 0);

    repeat (63) sendChar(`RESET_CHAR);
    checkValue("resetOut", resetOut, 0);
    sendChar(`RESET_CHAR);
    checkValue("resetOut", resetOut, 0);
    waitResetOut();
    repeat (4) @(posedge clock);
    checkValue("console output count", received.size(), 0);

    $display("Result: PASSED");
    $finish;
  end

endmodule
